//--- rtl/ll_sync_pkg.sv
package ll_sync_pkg;

  ////////////////////
  // Default widths and options
  ////////////////////

  // Defaults only, the top level sets the real values
  parameter int DEF_DATA_WIDTH        = 32;
  parameter int DEF_MARKER_WIDTH      = 1;
  parameter bit DEF_PERSISTENT_MARKER = 1'b0;
  parameter bit DEF_PERSISTENT_STROBE = 1'b0;
  parameter bit DEF_NO_MARKER         = 1'b0;

  ////////////////////
  // Link types
  ////////////////////

  // One link data word
  typedef logic [DEF_DATA_WIDTH-1:0]   ll_word_t;
  // User marker bits
  typedef logic [DEF_MARKER_WIDTH-1:0] ll_marker_t;
  // Delay count in clk_wr cycles, used for X, Y and Z
  typedef logic [15:0]                 ll_delay_t;

  // Transmit online sequencing
  typedef enum logic [2:0] {
    OFFLINE,
    WAIT_Z,
    WAIT_MRK1,
    WAIT_MRK2,
    WAIT_Y,
    ONLINE
  } ll_seq_state_t;

endpackage

//--- rtl/ll_word_if.sv
interface ll_word_if #(
  parameter int DATA_WIDTH   = ll_sync_pkg::DEF_DATA_WIDTH,
  parameter int MARKER_WIDTH = ll_sync_pkg::DEF_MARKER_WIDTH
);

  // Captured words, one per cycle
  logic [DATA_WIDTH-1:0]   tx_data;
  logic [DATA_WIDTH-1:0]   rx_data;
  // User marker and strobe of the transmit word
  logic [MARKER_WIDTH-1:0] tx_mrk;
  logic                    tx_stb;
  // Online levels after the synchronizers
  logic                    tx_online_s;
  logic                    rx_online_s;

  // Capture stage drives everything
  modport src (output tx_data, rx_data, tx_mrk, tx_stb, tx_online_s, rx_online_s);

  // Sequencer only looks at control
  modport seq (input tx_mrk, tx_stb, tx_online_s, rx_online_s);

  // Output gate only takes the payload
  modport sink (input tx_data, rx_data);

endinterface

//--- rtl/level_delay.sv
module level_delay (
  input  logic                  clk_wr,
  input  logic                  rst_wr_n,
  input  logic                  enable,
  input  ll_sync_pkg::ll_delay_t delay_value,
  output logic                  delayed_en
);

  import ll_sync_pkg::*;

  // Cycles seen with enable high
  ll_delay_t count;
  // Count has hit delay_value
  logic      count_done;

  // Counter runs only while enable is high
  // and parks once it meets the programmed value
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      count      <= '0;
      count_done <= 1'b0;
    end else if (!enable) begin
      count      <= '0;
      count_done <= 1'b0;
    end else if (count == delay_value) begin
      count_done <= 1'b1;
    end else begin
      count <= count + 16'd1;
    end
  end

  // One more flop so the rise lands D+1 edges after enable
  // Drops on the same edge that sees enable low
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      delayed_en <= 1'b0;
    end else begin
      delayed_en <= enable & count_done;
    end
  end

endmodule

//--- rtl/ll_online_capture.sv
module ll_online_capture (
  input  logic                   clk_wr,
  input  logic                   rst_wr_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  ll_sync_pkg::ll_word_t   tx_data,
  input  ll_sync_pkg::ll_word_t   rx_data,
  input  ll_sync_pkg::ll_marker_t tx_mrk,
  input  logic                   tx_stb,
  ll_word_if.src                 cap
);

  ////////////////////
  // Online synchronizers
  ////////////////////

  // Two flops each, online levels come from another clock domain
  logic [1:0] tx_online_sync;
  logic [1:0] rx_online_sync;

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_online_sync <= 2'b00;
      rx_online_sync <= 2'b00;
    end else begin
      tx_online_sync <= {tx_online_sync[0], tx_online};
      rx_online_sync <= {rx_online_sync[0], rx_online};
    end
  end

  assign cap.tx_online_s = tx_online_sync[1];
  assign cap.rx_online_s = rx_online_sync[1];

  ////////////////////
  // Word register
  ////////////////////

  // Single stage, one cycle ahead of the online levels
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      cap.tx_data <= '0;
      cap.rx_data <= '0;
      cap.tx_mrk  <= '0;
      cap.tx_stb  <= 1'b0;
    end else begin
      cap.tx_data <= tx_data;
      cap.rx_data <= rx_data;
      cap.tx_mrk  <= tx_mrk;
      cap.tx_stb  <= tx_stb;
    end
  end

endmodule

//--- rtl/ll_auto_sync.sv
module ll_auto_sync #(
  parameter int MARKER_WIDTH      = ll_sync_pkg::DEF_MARKER_WIDTH,
  parameter bit PERSISTENT_MARKER = ll_sync_pkg::DEF_PERSISTENT_MARKER,
  parameter bit PERSISTENT_STROBE = ll_sync_pkg::DEF_PERSISTENT_STROBE,
  parameter bit NO_MARKER         = ll_sync_pkg::DEF_NO_MARKER
) (
  input  logic                   clk_wr,
  input  logic                   rst_wr_n,
  ll_word_if.seq                 cap,
  input  ll_sync_pkg::ll_delay_t  delay_x_value,
  input  ll_sync_pkg::ll_delay_t  delay_y_value,
  input  ll_sync_pkg::ll_delay_t  delay_z_value,
  output ll_sync_pkg::ll_marker_t auto_mrk,
  output logic                   auto_stb,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay
);

  import ll_sync_pkg::*;

  ll_seq_state_t state;
  ll_seq_state_t state_nxt;

  logic z_done;
  logic y_en;
  logic sighting;
  logic mrk_window;
  logic first_hit;
  logic past_first;

  ////////////////////
  // Z delay on tx online
  ////////////////////

  level_delay z_dly (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (cap.tx_online_s),
    .delay_value (delay_z_value),
    .delayed_en  (z_done)
  );

  ////////////////////
  // Marker counting
  ////////////////////

  // Strobe stands in for the marker when there is none
  assign sighting = NO_MARKER ? cap.tx_stb : (|cap.tx_mrk);

  // Counting opens as soon as Z has expired, WAIT_Z included
  assign mrk_window = z_done & ((state == WAIT_Z) | (state == WAIT_MRK1));
  assign first_hit  = mrk_window & sighting;

  always_comb begin
    state_nxt = state;
    case (state)
      OFFLINE:   if (cap.tx_online_s) state_nxt = WAIT_Z;
      WAIT_Z: begin
        if (first_hit) begin
          state_nxt = WAIT_MRK2;
        end else if (z_done) begin
          state_nxt = WAIT_MRK1;
        end
      end
      WAIT_MRK1: if (first_hit) state_nxt = WAIT_MRK2;
      WAIT_MRK2: if (sighting) state_nxt = WAIT_Y;
      WAIT_Y:    if (tx_online_delay) state_nxt = ONLINE;
      default:   state_nxt = state;
    endcase
    // Losing online restarts the whole sequence
    if (!cap.tx_online_s) begin
      state_nxt = OFFLINE;
    end
  end

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      state <= OFFLINE;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////
  // Y delay after second marker
  ////////////////////

  // Held off by z_done too, so a drop clears Y one edge later
  assign y_en = z_done & ((state == WAIT_Y) | (state == ONLINE));

  level_delay y_dly (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (y_en),
    .delay_value (delay_y_value),
    .delayed_en  (tx_online_delay)
  );

  ////////////////////
  // Marker and strobe gating
  ////////////////////

  // First sighting already registered
  assign past_first = (state == WAIT_MRK2) | (state == WAIT_Y) | (state == ONLINE);

  // Marker word of the first sighting still goes out, later ones are dropped
  assign auto_mrk = PERSISTENT_MARKER ? cap.tx_mrk :
                    (cap.tx_mrk & {MARKER_WIDTH{~past_first}});

  // One strobe word only, on the first sighting
  assign auto_stb = PERSISTENT_STROBE ? cap.tx_stb : (cap.tx_stb & first_hit);

  ////////////////////
  // X delay on rx online
  ////////////////////

  level_delay x_dly (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (cap.rx_online_s),
    .delay_value (delay_x_value),
    .delayed_en  (rx_online_delay)
  );

endmodule

//--- rtl/ll_link_gate.sv
module ll_link_gate #(
  parameter int DATA_WIDTH = ll_sync_pkg::DEF_DATA_WIDTH
) (
  input  logic                   clk_wr,
  input  logic                   rst_wr_n,
  ll_word_if.sink                cap,
  input  ll_sync_pkg::ll_marker_t auto_mrk,
  input  logic                   auto_stb,
  input  logic                   tx_online_delay,
  input  logic                   rx_online_delay,
  output ll_sync_pkg::ll_word_t   tx_data_out,
  output ll_sync_pkg::ll_word_t   rx_data_out,
  output ll_sync_pkg::ll_marker_t tx_auto_mrk,
  output logic                   tx_auto_stb,
  output logic                   tx_online_out,
  output logic                   rx_online_out
);

  ////////////////////
  // Data gating
  ////////////////////

  // Words are zero until the matching side is online
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_data_out <= '0;
      rx_data_out <= '0;
    end else begin
      tx_data_out <= cap.tx_data & {DATA_WIDTH{tx_online_delay}};
      rx_data_out <= cap.rx_data & {DATA_WIDTH{rx_online_delay}};
    end
  end

  ////////////////////
  // Control outputs
  ////////////////////

  // Same one-cycle stage as the data, keeps everything aligned
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_auto_mrk   <= '0;
      tx_auto_stb   <= 1'b0;
      tx_online_out <= 1'b0;
      rx_online_out <= 1'b0;
    end else begin
      tx_auto_mrk   <= auto_mrk;
      tx_auto_stb   <= auto_stb;
      tx_online_out <= tx_online_delay;
      rx_online_out <= rx_online_delay;
    end
  end

endmodule

//--- rtl/ll_sync_top.sv
module ll_sync_top #(
  parameter int DATA_WIDTH        = ll_sync_pkg::DEF_DATA_WIDTH,
  parameter int MARKER_WIDTH      = ll_sync_pkg::DEF_MARKER_WIDTH,
  parameter bit PERSISTENT_MARKER = ll_sync_pkg::DEF_PERSISTENT_MARKER,
  parameter bit PERSISTENT_STROBE = ll_sync_pkg::DEF_PERSISTENT_STROBE,
  parameter bit NO_MARKER         = ll_sync_pkg::DEF_NO_MARKER
) (
  input  logic                   clk_wr,
  input  logic                   rst_wr_n,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  ll_sync_pkg::ll_word_t   tx_data,
  input  ll_sync_pkg::ll_word_t   rx_data,
  input  ll_sync_pkg::ll_marker_t tx_mrk,
  input  logic                   tx_stb,
  input  ll_sync_pkg::ll_delay_t  delay_x_value,
  input  ll_sync_pkg::ll_delay_t  delay_y_value,
  input  ll_sync_pkg::ll_delay_t  delay_z_value,
  output ll_sync_pkg::ll_word_t   tx_data_out,
  output ll_sync_pkg::ll_word_t   rx_data_out,
  output ll_sync_pkg::ll_marker_t tx_auto_mrk,
  output logic                   tx_auto_stb,
  output logic                   tx_online_out,
  output logic                   rx_online_out
);

  // Sequencer to output gate
  ll_sync_pkg::ll_marker_t auto_mrk;
  logic                   auto_stb;
  logic                   tx_online_delay;
  logic                   rx_online_delay;

  // Captured word and synchronized online levels
  ll_word_if #(.DATA_WIDTH(DATA_WIDTH), .MARKER_WIDTH(MARKER_WIDTH)) cap_if ();

  // Input side
  ll_online_capture u_capture (
    .clk_wr    (clk_wr),
    .rst_wr_n  (rst_wr_n),
    .tx_online (tx_online),
    .rx_online (rx_online),
    .tx_data   (tx_data),
    .rx_data   (rx_data),
    .tx_mrk    (tx_mrk),
    .tx_stb    (tx_stb),
    .cap       (cap_if.src)
  );

  // Delays and marker sequencing
  ll_auto_sync #(
    .MARKER_WIDTH      (MARKER_WIDTH),
    .PERSISTENT_MARKER (PERSISTENT_MARKER),
    .PERSISTENT_STROBE (PERSISTENT_STROBE),
    .NO_MARKER         (NO_MARKER)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .rst_wr_n        (rst_wr_n),
    .cap             (cap_if.seq),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .auto_mrk        (auto_mrk),
    .auto_stb        (auto_stb),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  // Output side
  ll_link_gate #(.DATA_WIDTH(DATA_WIDTH)) u_link_gate (
    .clk_wr          (clk_wr),
    .rst_wr_n        (rst_wr_n),
    .cap             (cap_if.sink),
    .auto_mrk        (auto_mrk),
    .auto_stb        (auto_stb),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_data_out     (tx_data_out),
    .rx_data_out     (rx_data_out),
    .tx_auto_mrk     (tx_auto_mrk),
    .tx_auto_stb     (tx_auto_stb),
    .tx_online_out   (tx_online_out),
    .rx_online_out   (rx_online_out)
  );

endmodule

//--- bench/ll_sync_props.sv
module ll_sync_props #(
  parameter bit PERSISTENT_MARKER = ll_sync_pkg::DEF_PERSISTENT_MARKER,
  parameter bit PERSISTENT_STROBE = ll_sync_pkg::DEF_PERSISTENT_STROBE
) (
  input logic                       clk_wr,
  input logic                       rst_wr_n,
  input ll_sync_pkg::ll_seq_state_t state,
  input ll_sync_pkg::ll_marker_t    auto_mrk,
  input logic                       auto_stb,
  input logic                       tx_online_delay,
  input logic                       z_done,
  input logic                       first_hit
);

  import ll_sync_pkg::*;

  // First sighting seen since Z expired, cleared when the link drops
  logic mrk_seen;

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      mrk_seen <= 1'b0;
    end else if (!z_done) begin
      mrk_seen <= 1'b0;
    end else if (first_hit) begin
      mrk_seen <= 1'b1;
    end
  end

  // Delayed tx level only comes up at the end of the Y wait
  a_online_rise: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    $rose(tx_online_delay) |-> (state inside {WAIT_Y, ONLINE}))
    else $error("tx_online_delay rose outside the online states");

  // Single strobe word per sequence
  a_single_stb: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    (!PERSISTENT_STROBE && auto_stb) |=> !auto_stb)
    else $error("auto_stb high on two consecutive cycles");

  // Marker removed once the first sighting has gone out
  a_mrk_gone: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    (!PERSISTENT_MARKER && mrk_seen && z_done) |-> (auto_mrk == '0))
    else $error("auto_mrk not zero after the first sighting");

endmodule

bind ll_auto_sync ll_sync_props #(
  .PERSISTENT_MARKER (PERSISTENT_MARKER),
  .PERSISTENT_STROBE (PERSISTENT_STROBE)
) i_props (
  .clk_wr          (clk_wr),
  .rst_wr_n        (rst_wr_n),
  .state           (state),
  .auto_mrk        (auto_mrk),
  .auto_stb        (auto_stb),
  .tx_online_delay (tx_online_delay),
  .z_done          (z_done),
  .first_hit       (first_hit)
);

//--- bench/ll_sync_checker.sv
module ll_sync_checker #(
  parameter bit PERSISTENT_MARKER = ll_sync_pkg::DEF_PERSISTENT_MARKER,
  parameter bit PERSISTENT_STROBE = ll_sync_pkg::DEF_PERSISTENT_STROBE,
  parameter bit NO_MARKER         = ll_sync_pkg::DEF_NO_MARKER
) (
  input  logic                    clk_wr,
  input  logic                    rst_wr_n,
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  ll_sync_pkg::ll_word_t   tx_data,
  input  ll_sync_pkg::ll_word_t   rx_data,
  input  ll_sync_pkg::ll_marker_t tx_mrk,
  input  logic                    tx_stb,
  input  ll_sync_pkg::ll_delay_t  delay_x_value,
  input  ll_sync_pkg::ll_delay_t  delay_y_value,
  input  ll_sync_pkg::ll_delay_t  delay_z_value,
  input  ll_sync_pkg::ll_word_t   tx_data_out,
  input  ll_sync_pkg::ll_word_t   rx_data_out,
  input  ll_sync_pkg::ll_marker_t tx_auto_mrk,
  input  logic                    tx_auto_stb,
  input  logic                    tx_online_out,
  input  logic                    rx_online_out,
  output int                      mismatches
);

  import ll_sync_pkg::*;

  ////////////////////
  // Reference model
  ////////////////////

  // Sequencing rule, one step per clock
  function automatic ll_seq_state_t next_phase(ll_seq_state_t cur, logic on_s, logic z_dn,
                                               logic sight, logic y_dn);
    if (!on_s) return OFFLINE;
    case (cur)
      OFFLINE:   return WAIT_Z;
      WAIT_Z:    return z_dn ? (sight ? WAIT_MRK2 : WAIT_MRK1) : WAIT_Z;
      WAIT_MRK1: return (z_dn && sight) ? WAIT_MRK2 : WAIT_MRK1;
      WAIT_MRK2: return sight ? WAIT_Y : WAIT_MRK2;
      WAIT_Y:    return y_dn ? ONLINE : WAIT_Y;
      default:   return cur;
    endcase
  endfunction

  // Consecutive high samples of a delay enable
  function automatic int run_length(logic en, int run);
    return en ? ((run < 1000000) ? run + 1 : run) : 0;
  endfunction

  // Level is up D+1 edges after the first high sample
  function automatic logic level_out(logic en, int run, ll_delay_t d);
    return en && (run >= int'(d) + 2);
  endfunction

  logic          s1_tx, s2_tx, s1_rx, s2_rx;
  ll_word_t      cw_tx, cw_rx;
  ll_marker_t    cw_mrk;
  logic          cw_stb;
  int            z_run, y_run, x_run;
  logic          z_out, y_out, x_out;
  ll_seq_state_t phase;

  // Expected registered outputs
  ll_word_t      e_tx_data, e_rx_data;
  ll_marker_t    e_mrk;
  logic          e_stb, e_tx_on, e_rx_on;

  always @(posedge clk_wr or negedge rst_wr_n) begin
    logic          sight;
    logic          hit;
    logic          y_en;
    ll_seq_state_t nxt;
    if (!rst_wr_n) begin
      {s1_tx, s2_tx, s1_rx, s2_rx} = '0;
      cw_tx = '0;
      cw_rx = '0;
      cw_mrk = '0;
      cw_stb = 1'b0;
      {z_run, y_run, x_run} = '0;
      {z_out, y_out, x_out} = '0;
      phase = OFFLINE;
      e_tx_data = '0;
      e_rx_data = '0;
      e_mrk = '0;
      {e_stb, e_tx_on, e_rx_on} = '0;
    end else begin
      // Everything below reads the state before this edge
      sight = NO_MARKER ? cw_stb : (|cw_mrk);
      hit   = z_out && (phase inside {WAIT_Z, WAIT_MRK1}) && sight;
      y_en  = z_out && (phase inside {WAIT_Y, ONLINE});
      nxt   = next_phase(phase, s2_tx, z_out, sight, y_out);
      e_tx_data = y_out ? cw_tx : '0;
      e_rx_data = x_out ? cw_rx : '0;
      e_mrk = (PERSISTENT_MARKER || !(phase inside {WAIT_MRK2, WAIT_Y, ONLINE})) ? cw_mrk : '0;
      e_stb = PERSISTENT_STROBE ? cw_stb : (cw_stb && hit);
      e_tx_on = y_out;
      e_rx_on = x_out;
      z_run = run_length(s2_tx, z_run);
      z_out = level_out(s2_tx, z_run, delay_z_value);
      y_run = run_length(y_en, y_run);
      y_out = level_out(y_en, y_run, delay_y_value);
      x_run = run_length(s2_rx, x_run);
      x_out = level_out(s2_rx, x_run, delay_x_value);
      phase = nxt;
      // Synchronizers and capture register
      s2_tx = s1_tx;
      s1_tx = tx_online;
      s2_rx = s1_rx;
      s1_rx = rx_online;
      cw_tx = tx_data;
      cw_rx = rx_data;
      cw_mrk = tx_mrk;
      cw_stb = tx_stb;
    end
  end

  ////////////////////
  // Comparison
  ////////////////////

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  initial mismatches = 0;

  // Mid-cycle, outputs have settled
  always @(negedge clk_wr) begin
    if (rst_wr_n) begin
      compare("tx_data_out", tx_data_out, e_tx_data);
      compare("rx_data_out", rx_data_out, e_rx_data);
      compare("tx_auto_mrk", 32'(tx_auto_mrk), 32'(e_mrk));
      compare("tx_auto_stb", 32'(tx_auto_stb), 32'(e_stb));
      compare("tx_online_out", 32'(tx_online_out), 32'(e_tx_on));
      compare("rx_online_out", 32'(rx_online_out), 32'(e_rx_on));
    end
  end

endmodule

//--- bench/ll_sync_tb.sv
module ll_sync_tb;

  import ll_sync_pkg::*;

  logic       clk_wr;
  logic       rst_wr_n;
  logic       tx_online, rx_online;
  ll_word_t   tx_data, rx_data;
  ll_marker_t tx_mrk;
  logic       tx_stb;
  ll_delay_t  delay_x_value, delay_y_value, delay_z_value;
  ll_word_t   tx_data_out, rx_data_out;
  ll_marker_t tx_auto_mrk;
  logic       tx_auto_stb, tx_online_out, rx_online_out;
  int         mismatches;

  int seed;
  int fails;
  int tests_run;
  int tests_failed;
  int mrk_cnt;
  logic mrk_en;
  int seq_err, mrk_err, stb_err;
  int rise1, rise2;
  int n;
  int base;

  always #10 clk_wr = ~clk_wr;

  ll_sync_top i_ll_sync_top (.*);

  ll_sync_checker chk (.*);

  ////////////////////
  // Helpers
  ////////////////////

  // Next cycle, inputs change 2 units after the edge
  task automatic step();
    @(posedge clk_wr);
    #2;
    tx_data = $random(seed);
    rx_data = $random(seed);
    // Marker on every fourth word
    tx_mrk = (mrk_en && (mrk_cnt % 4 == 3)) ? '1 : '0;
    mrk_cnt++;
  endtask

  task automatic report(input string name, input int errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  task automatic check_zero(input string name, input logic [31:0] got, inout int errs);
    if (got !== 32'h0) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, 32'h0);
      errs++;
    end
  endtask

  // One full transmit bring-up, returns cycles to tx_online_out
  task automatic run_tx(output int rise);
    int   k;
    int   stb_pulses;
    logic stb_done;
    stb_pulses = 0;
    stb_done = 1'b0;
    mrk_cnt = 0;
    mrk_en = 1'b1;
    tx_stb = 1'b1;
    tx_online = 1'b1;
    k = 0;
    while (!tx_online_out && k < 400) begin
      step();
      k++;
      if (stb_done) check_zero("tx_auto_mrk", 32'(tx_auto_mrk), mrk_err);
      if (tx_auto_stb) begin
        stb_pulses++;
        stb_done = 1'b1;
        if (tx_auto_mrk == '0) begin
          $display("strobe word came without its marker");
          stb_err++;
        end
      end
    end
    if (!tx_online_out) begin
      $display("timeout waiting for tx_online_out to rise");
      seq_err++;
    end
    rise = k;
    // Settled link, no more markers or strobes
    repeat (20) begin
      step();
      check_zero("tx_auto_mrk", 32'(tx_auto_mrk), mrk_err);
      if (tx_auto_stb) stb_pulses++;
      if (!tx_online_out) begin
        $display("MISMATCH tx_online_out got 0x%h expected 0x%h", tx_online_out, 1'b1);
        seq_err++;
      end
    end
    if (stb_pulses != 1) begin
      $display("expected one strobe word, saw %0d", stb_pulses);
      stb_err++;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    seed = 25;
    clk_wr = 1'b0;
    rst_wr_n = 1'b0;
    {tx_online, rx_online, tx_stb} = '0;
    tx_data = '0;
    rx_data = '0;
    tx_mrk = '0;
    delay_x_value = 16'd9;
    delay_y_value = 16'd7;
    delay_z_value = 16'd5;
    {fails, tests_run, tests_failed, mrk_cnt} = '0;
    {seq_err, mrk_err, stb_err} = '0;
    mrk_en = 1'b0;
    repeat (10) @(posedge clk_wr);
    #2;
    rst_wr_n = 1'b1;

    // Idle outputs after reset
    base = mismatches;
    seq_err = 0;
    repeat (10) begin
      step();
      check_zero("tx_data_out", tx_data_out, seq_err);
      check_zero("rx_data_out", rx_data_out, seq_err);
      check_zero("tx_auto_mrk", 32'(tx_auto_mrk), seq_err);
      check_zero("tx_auto_stb", 32'(tx_auto_stb), seq_err);
      check_zero("tx_online_out", 32'(tx_online_out), seq_err);
      check_zero("rx_online_out", 32'(rx_online_out), seq_err);
    end
    report("reset_idle", seq_err + mismatches - base);
    fails += seq_err;

    // Transmit bring-up covers sequencing, marker and strobe
    base = mismatches;
    {seq_err, mrk_err, stb_err} = '0;
    run_tx(rise1);
    report("tx_sequence", seq_err + mismatches - base);
    report("marker_gate", mrk_err);
    report("strobe_gate", stb_err);
    fails += seq_err + mrk_err + stb_err;

    // Receive side, 2 sync + X+1 + capture edge + output register
    base = mismatches;
    seq_err = 0;
    rx_online = 1'b1;
    n = 0;
    while (!rx_online_out && n < 100) begin
      step();
      n++;
    end
    if (!rx_online_out) begin
      $display("timeout waiting for rx_online_out to rise");
      seq_err++;
    end else if (n != int'(delay_x_value) + 5) begin
      $display("rx_online_out rose after %0d cycles, expected %0d", n, delay_x_value + 5);
      seq_err++;
    end
    repeat (10) step();
    report("rx_delay", seq_err + mismatches - base);
    fails += seq_err;

    // Drop and bring tx back up
    base = mismatches;
    {seq_err, mrk_err, stb_err} = '0;
    tx_online = 1'b0;
    mrk_en = 1'b0;
    n = 0;
    while (tx_online_out && n < 20) begin
      step();
      n++;
    end
    if (tx_online_out || n > 5) begin
      $display("tx_online_out did not drop in time, %0d cycles", n);
      seq_err++;
    end
    repeat (8) step();
    run_tx(rise2);
    if (rise2 != rise1) begin
      $display("second run rose after %0d cycles, first after %0d", rise2, rise1);
      seq_err++;
    end
    report("tx_restart", seq_err + mrk_err + stb_err + mismatches - base);
    fails += seq_err + mrk_err + stb_err;

    $display("%0d tests, %0d failed, %0d check errors, %0d mismatches",
             tests_run, tests_failed, fails, mismatches);
    if (fails == 0 && mismatches == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- ll_sync.f
rtl/ll_sync_pkg.sv
rtl/ll_word_if.sv
rtl/level_delay.sv
rtl/ll_online_capture.sv
rtl/ll_auto_sync.sv
rtl/ll_link_gate.sv
rtl/ll_sync_top.sv
bench/ll_sync_props.sv
bench/ll_sync_checker.sv
bench/ll_sync_tb.sv

//--- Makefile
TOP = ll_sync_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f ll_sync.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
